//--- build.f
tinker_pkg.sv
fetch_unit.sv
decode_stage.sv
execute_stage.sv
memory_writeback.sv
tinker_core.sv
tinker_properties.sv
tb_tinker_core.sv
+incdir+.

//--- decode_stage.sv
`default_nettype none

module decode_stage (
    input  wire                        clk,
    input  wire                        reset,
    input  wire tinker_pkg::if_id_t    if_id,
    input  wire tinker_pkg::redirect_t redirect,
    input  wire tinker_pkg::wb_t       wb,
    output logic                       stall,
    output logic                       halt_fetch,
    output tinker_pkg::id_ex_t         id_ex
);
    import tinker_pkg::*;

    word_t    regs [32];

    opcode_t  op;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    imm_t     imm;
    logic     uses_rt;
    logic     reads_rs;
    logic     reads_rd;
    logic     load_use;
    id_ex_t   id_next;

    // instruction fields
    assign op  = opcode_t'(if_id.instr[31:27]);
    assign rd  = if_id.instr[26:22];
    assign rs  = if_id.instr[21:17];
    assign rt  = if_id.instr[16:12];
    assign imm = if_id.instr[11:0];

    // immediate forms take L as operand 2
    assign uses_rt = !(op inside {op_addi, op_subi, op_shftri, op_shftli,
                                  op_movl, op_brr_l, op_store, op_load});
    assign reads_rs = !(op inside {op_addi, op_subi, op_movl, op_br,
                                   op_brr_rd, op_brr_l, op_halt});
    // rd as a source: accumulate forms, movl merge, store base, branch targets
    assign reads_rd = op inside {op_addi, op_subi, op_movl, op_store,
                                 op_br, op_brr_rd, op_brnz, op_brgt};

    // register file, written from writeback
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.write) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // read with bypass of the write in flight this cycle
    function automatic word_t read_reg(reg_idx_t idx);
        word_t v;
        v = regs[idx];
        if (wb.write && wb.rd == idx) begin
            v = wb.value;
        end
        return v;
    endfunction

    // load in execute whose rd is a source here
    assign load_use = if_id.valid && id_ex.valid && id_ex.op == op_load &&
                      ((reads_rs && id_ex.rd == rs) ||
                       (uses_rt && id_ex.rd == rt) ||
                       (reads_rd && id_ex.rd == rd));
    assign stall = load_use;

    // halt moving on to execute, fetch stops after it
    assign halt_fetch = if_id.valid && op == op_halt && !load_use && !redirect.taken;

    always_comb begin
        id_next.valid   = if_id.valid;
        id_next.op      = op;
        id_next.rd      = rd;
        id_next.rs      = rs;
        id_next.rt      = rt;
        id_next.imm     = imm;
        id_next.pc      = if_id.pc;
        id_next.uses_rt = uses_rt;
        id_next.rs_val  = read_reg(rs);
        id_next.rt_val  = read_reg(rt);
        id_next.rd_val  = read_reg(rd);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_next;
            // bubble on squash or on the load-use hold
            if (redirect.taken || load_use) begin
                id_ex.valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- execute_stage.sv
`default_nettype none

module execute_stage (
    input  wire                     clk,
    input  wire                     reset,
    input  wire tinker_pkg::id_ex_t id_ex,
    input  wire tinker_pkg::wb_t    wb,
    output tinker_pkg::redirect_t   redirect,
    output tinker_pkg::ex_mem_t     ex_mem
);
    import tinker_pkg::*;

    word_t   rs_f;
    word_t   rt_f;
    word_t   rd_f;
    word_t   imm_ext;
    word_t   op1;
    word_t   op2;
    ex_mem_t ex_next;

    // ex_mem is newer than wb, so it is checked last and wins
    function automatic word_t forward(reg_idx_t idx, word_t reg_val);
        word_t v;
        v = reg_val;
        if (wb.write && wb.rd == idx) begin
            v = wb.value;
        end
        if (ex_mem.valid && ex_mem.reg_write && ex_mem.rd == idx) begin
            v = ex_mem.result;
        end
        return v;
    endfunction

    assign rs_f    = forward(id_ex.rs, id_ex.rs_val);
    assign rt_f    = forward(id_ex.rt, id_ex.rt_val);
    assign rd_f    = forward(id_ex.rd, id_ex.rd_val);
    assign imm_ext = {{52{id_ex.imm[11]}}, id_ex.imm};

    // addi/subi accumulate into rd
    assign op1 = (id_ex.op inside {op_addi, op_subi}) ? rd_f : rs_f;
    assign op2 = id_ex.uses_rt ? rt_f : imm_ext;

    always_comb begin
        ex_next            = '0;
        ex_next.valid      = id_ex.valid;
        ex_next.rd         = id_ex.rd;
        ex_next.store_data = rs_f;
        redirect.taken     = 1'b0;
        redirect.target    = rd_f[31:0];
        case (id_ex.op)
            op_add, op_addi:     ex_next.result = op1 + op2;
            op_sub, op_subi:     ex_next.result = op1 - op2;
            op_and:              ex_next.result = op1 & op2;
            op_or:               ex_next.result = op1 | op2;
            op_xor:              ex_next.result = op1 ^ op2;
            op_not:              ex_next.result = ~op1;
            op_shftr, op_shftri: ex_next.result = op1 >> op2;
            op_shftl, op_shftli: ex_next.result = op1 << op2;
            op_mov:              ex_next.result = op1;
            // movl only replaces the low 12 bits of rd
            op_movl:             ex_next.result = {rd_f[63:12], id_ex.imm};
            op_load: begin
                ex_next.mem_read = 1'b1;
                ex_next.addr     = rs_f[31:0] + imm_ext[31:0];
            end
            op_store: begin
                ex_next.mem_write = 1'b1;
                ex_next.addr      = rd_f[31:0] + imm_ext[31:0];
            end
            op_br:     redirect.taken = 1'b1;
            op_brr_rd: begin
                redirect.taken  = 1'b1;
                redirect.target = id_ex.pc + rd_f[31:0];
            end
            op_brr_l: begin
                redirect.taken  = 1'b1;
                redirect.target = id_ex.pc + imm_ext[31:0];
            end
            op_brnz:   redirect.taken = (rs_f != '0);
            op_brgt:   redirect.taken = ($signed(rs_f) > $signed(rt_f));
            op_halt:   ex_next.is_halt = 1'b1;
            default:   ex_next.result = '0;
        endcase
        // results that land in a register
        ex_next.reg_write = id_ex.valid &&
                            (id_ex.op inside {op_add, op_addi, op_sub, op_subi,
                                              op_and, op_or, op_xor, op_not,
                                              op_shftr, op_shftri, op_shftl, op_shftli,
                                              op_mov, op_movl, op_load});
        // a bubble has no side effects
        if (!id_ex.valid) begin
            ex_next.mem_read  = 1'b0;
            ex_next.mem_write = 1'b0;
            ex_next.is_halt   = 1'b0;
            redirect.taken    = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_next;
        end
    end

endmodule

`default_nettype wire

//--- fetch_unit.sv
`default_nettype none

module fetch_unit (
    input  wire                        clk,
    input  wire                        reset,
    output tinker_pkg::addr_t          imem_addr,
    input  wire tinker_pkg::instr_t    imem_data,
    input  wire                        stall,
    input  wire                        halt_fetch,
    input  wire tinker_pkg::redirect_t redirect,
    output tinker_pkg::if_id_t         if_id
);
    import tinker_pkg::*;

    addr_t        pc;
    fetch_state_t state;

    // instruction memory answers in the same cycle
    assign imem_addr = pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc    <= reset_pc;
            state <= fetch_run;
            if_id <= '0;
        end else if (redirect.taken) begin
            // branch in execute, drop what was just fetched
            pc          <= redirect.target;
            if_id.valid <= 1'b0;
        end else if (halt_fetch) begin
            // halt heading to execute, nothing behind it may issue
            state       <= fetch_halted;
            if_id.valid <= 1'b0;
        end else if (stall) begin
            // load-use, keep pc and if_id as they are
            pc <= pc;
        end else if (state == fetch_halted) begin
            if_id.valid <= 1'b0;
        end else begin
            pc          <= pc + instr_bytes;
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.instr <= imem_data;
        end
    end

endmodule

`default_nettype wire

//--- memory_writeback.sv
`default_nettype none

module memory_writeback (
    input  wire                      clk,
    input  wire                      reset,
    input  wire tinker_pkg::ex_mem_t ex_mem,
    output tinker_pkg::addr_t        dmem_addr,
    input  wire tinker_pkg::word_t   dmem_rdata,
    output tinker_pkg::word_t        dmem_wdata,
    output logic                     dmem_write,
    output tinker_pkg::wb_t          wb,
    output logic                     hlt
);

    // data port straight off ex_mem, read data comes back this cycle
    assign dmem_addr  = ex_mem.addr;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_write = ex_mem.valid && ex_mem.mem_write;

    // memory/writeback register, load data or alu result
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb.write <= ex_mem.valid && ex_mem.reg_write;
            wb.rd    <= ex_mem.rd;
            wb.value <= ex_mem.mem_read ? dmem_rdata : ex_mem.result;
        end
    end

    // sticky, rises as the halt enters writeback
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hlt <= 1'b0;
        end else if (ex_mem.valid && ex_mem.is_halt) begin
            hlt <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_tinker_core \
    -f build.f -o tb_tinker_core_sim

./obj_dir/tb_tinker_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
grep -q "PASS: all tests" sim.log

//--- tb_tinker_model.svh
`ifndef TB_TINKER_MODEL_SVH
`define TB_TINKER_MODEL_SVH

// instruction word from its fields
function automatic instr_t encode(opcode_t op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt,
                                  imm_t l);
    return {op, rd, rs, rt, l};
endfunction

// append one instruction after the program so far
function automatic void emit(instr_t i);
    addr_t a;
    a = reset_pc + addr_t'(4 * prog_len);
    for (int k = 0; k < 4; k++) begin
        image[a[15:0] + 16'(k)] = i[8*k +: 8];
    end
    prog_len++;
endfunction

// little-endian data word into the image
function automatic void put_word(addr_t a, word_t w);
    for (int k = 0; k < 8; k++) begin
        image[a[15:0] + 16'(k)] = w[8*k +: 8];
    end
endfunction

function automatic word_t pc_at(int idx);
    return word_t'(reset_pc) + word_t'(4 * idx);
endfunction

function automatic void clear_image();
    for (int k = 0; k < 65536; k++) begin
        image[k] = 8'h00;
    end
    prog_len = 0;
endfunction

function automatic word_t model_read(addr_t a);
    word_t w;
    for (int k = 0; k < 8; k++) begin
        w[8*k +: 8] = model_mem[a[15:0] + 16'(k)];
    end
    return w;
endfunction

// isa level run of the image, fills the expected store queues
function automatic void run_model();
    word_t  r [32];
    addr_t  pc;
    addr_t  next;
    addr_t  a;
    instr_t i;
    word_t  sx;
    logic [4:0] op;
    reg_idx_t   rd;
    reg_idx_t   rs;
    reg_idx_t   rt;
    exp_addr.delete();
    exp_data.delete();
    model_mem = image;
    for (int k = 0; k < 32; k++) begin
        r[k] = '0;
    end
    pc = reset_pc;
    for (int step = 0; step < 4000; step++) begin
        for (int k = 0; k < 4; k++) begin
            i[8*k +: 8] = model_mem[pc[15:0] + 16'(k)];
        end
        op   = i[31:27];
        rd   = i[26:22];
        rs   = i[21:17];
        rt   = i[16:12];
        sx   = {{52{i[11]}}, i[11:0]};
        next = pc + 32'd4;
        case (op)
            op_add:    r[rd] = r[rs] + r[rt];
            op_addi:   r[rd] = r[rd] + sx;
            op_sub:    r[rd] = r[rs] - r[rt];
            op_subi:   r[rd] = r[rd] - sx;
            op_and:    r[rd] = r[rs] & r[rt];
            op_or:     r[rd] = r[rs] | r[rt];
            op_xor:    r[rd] = r[rs] ^ r[rt];
            op_not:    r[rd] = ~r[rs];
            op_shftr:  r[rd] = r[rs] >> r[rt];
            op_shftri: r[rd] = r[rs] >> sx;
            op_shftl:  r[rd] = r[rs] << r[rt];
            op_shftli: r[rd] = r[rs] << sx;
            op_mov:    r[rd] = r[rs];
            // only the low 12 bits change
            op_movl:   r[rd] = {r[rd][63:12], i[11:0]};
            op_load: begin
                a     = r[rs][31:0] + sx[31:0];
                r[rd] = model_read(a);
            end
            op_store: begin
                a = r[rd][31:0] + sx[31:0];
                exp_addr.push_back(a);
                exp_data.push_back(r[rs]);
                for (int k = 0; k < 8; k++) begin
                    model_mem[a[15:0] + 16'(k)] = r[rs][8*k +: 8];
                end
            end
            op_br:     next = r[rd][31:0];
            op_brr_rd: next = pc + r[rd][31:0];
            op_brr_l:  next = pc + sx[31:0];
            op_brnz:   if (r[rs] != '0) next = r[rd][31:0];
            op_brgt:   if ($signed(r[rs]) > $signed(r[rt])) next = r[rd][31:0];
            op_halt:   return;
            default:   ;
        endcase
        pc = next;
    end
endfunction

`endif

//--- tb_tinker_core.sv
`default_nettype none

module tb_tinker_core;
    import tinker_pkg::*;

    logic   clk;
    logic   reset;
    addr_t  imem_addr;
    instr_t imem_data;
    addr_t  dmem_addr;
    word_t  dmem_rdata;
    word_t  dmem_wdata;
    logic   dmem_write;
    logic   hlt;

    // image is what a test loads, mem is what the core sees
    bit [7:0] image     [65536];
    bit [7:0] mem       [65536];
    bit [7:0] model_mem [65536];
    int       prog_len;
    addr_t    exp_addr [$];
    word_t    exp_data [$];
    int       errors;
    int       failed;
    int       tests;
    integer   seed = 68285;

    `include "tb_tinker_model.svh"

    tinker_core UUT (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_rdata (dmem_rdata),
        .dmem_wdata (dmem_wdata),
        .dmem_write (dmem_write),
        .hlt        (hlt)
    );

    bind tinker_core tinker_properties u_props (
        .clk        (clk),
        .reset      (reset),
        .hlt        (hlt),
        .dmem_write (dmem_write),
        .imem_addr  (imem_addr)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // combinational reads, little-endian
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            imem_data[8*k +: 8] = mem[imem_addr[15:0] + 16'(k)];
        end
        for (int k = 0; k < 8; k++) begin
            dmem_rdata[8*k +: 8] = mem[dmem_addr[15:0] + 16'(k)];
        end
    end

    // reset reloads the test image
    always @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < 65536; k++) begin
                mem[k] <= image[k];
            end
        end else if (dmem_write) begin
            for (int k = 0; k < 8; k++) begin
                mem[dmem_addr[15:0] + 16'(k)] <= dmem_wdata[8*k +: 8];
            end
        end
    end

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // each store pulse against the next expected store
    always @(negedge clk) begin
        if (!reset && dmem_write) begin
            if (exp_addr.size() == 0) begin
                $display("store to %h at t=%0t was not expected", dmem_addr, $time);
                errors++;
            end else begin
                check_addr("dmem_addr", dmem_addr, exp_addr.pop_front());
                check_word("dmem_wdata", dmem_wdata, exp_data.pop_front());
            end
        end
    end

    function automatic word_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic void store_rs(reg_idx_t src, imm_t l);
        emit(encode(op_store, 5'd0, src, 5'd0, l));
    endfunction

    task automatic run_test(string name);
        int err_before;
        int n;
        err_before = errors;
        tests++;
        run_model();
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        n = 0;
        while (!hlt && n < 2000) begin
            @(posedge clk);
            n++;
        end
        if (!hlt) begin
            $display("timeout, hlt never rose in test %s", name);
            errors++;
        end
        // a few more cycles so any stray store shows up
        n = 0;
        while (n < 10) begin
            @(posedge clk);
            n++;
        end
        if (exp_addr.size() != 0) begin
            $display("test %s ended with %0d stores missing", name, exp_addr.size());
            errors++;
        end
        if (errors != err_before) begin
            failed++;
        end
        $display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
    endtask

    initial begin
        reset = 1'b1;
        errors = 0;
        failed = 0;
        tests = 0;

        // back-to-back alu ops, forwarding from both stages
        clear_image();
        for (int k = 0; k < 4; k++) begin
            put_word(addr_t'(32'h400 + 8 * k), rand_word());
            emit(encode(op_load, reg_idx_t'(k + 1), 5'd0, 5'd0, imm_t'(12'h400 + 8 * k)));
        end
        put_word(32'h420, word_t'(6'($random(seed))));
        emit(encode(op_load, 5'd12, 5'd0, 5'd0, 12'h420));
        emit(encode(op_add, 5'd5, 5'd1, 5'd2, 12'h0));
        emit(encode(op_sub, 5'd6, 5'd5, 5'd3, 12'h0));
        emit(encode(op_and, 5'd7, 5'd6, 5'd5, 12'h0));
        emit(encode(op_or, 5'd8, 5'd7, 5'd4, 12'h0));
        emit(encode(op_xor, 5'd9, 5'd8, 5'd6, 12'h0));
        emit(encode(op_not, 5'd10, 5'd9, 5'd0, 12'h0));
        emit(encode(op_shftr, 5'd11, 5'd1, 5'd12, 12'h0));
        emit(encode(op_shftl, 5'd13, 5'd2, 5'd12, 12'h0));
        for (int k = 5; k <= 13; k++) begin
            store_rs(reg_idx_t'(k), imm_t'(12'h600 + 8 * k));
        end
        emit(encode(op_halt, 5'd0, 5'd0, 5'd0, 12'h0));
        run_test("alu");

        // immediate forms, L may be negative
        clear_image();
        put_word(32'h400, rand_word());
        put_word(32'h408, rand_word());
        emit(encode(op_load, 5'd1, 5'd0, 5'd0, 12'h400));
        emit(encode(op_load, 5'd2, 5'd0, 5'd0, 12'h408));
        emit(encode(op_addi, 5'd1, 5'd0, 5'd0, imm_t'($random(seed))));
        // subi always with a negative L
        emit(encode(op_subi, 5'd2, 5'd0, 5'd0, imm_t'($random(seed)) | 12'h800));
        emit(encode(op_shftri, 5'd3, 5'd1, 5'd0, imm_t'(6'($random(seed)))));
        emit(encode(op_shftli, 5'd4, 5'd2, 5'd0, imm_t'(6'($random(seed)))));
        emit(encode(op_shftri, 5'd6, 5'd2, 5'd0, 12'hfff));
        emit(encode(op_mov, 5'd5, 5'd1, 5'd0, 12'h0));
        emit(encode(op_movl, 5'd5, 5'd0, 5'd0, imm_t'($random(seed))));
        for (int k = 1; k <= 6; k++) begin
            store_rs(reg_idx_t'(k), imm_t'(12'h600 + 8 * k));
        end
        emit(encode(op_halt, 5'd0, 5'd0, 5'd0, 12'h0));
        run_test("immediate");

        // consumers right behind loads
        clear_image();
        put_word(32'h400, rand_word());
        put_word(32'h408, rand_word());
        put_word(32'h410, rand_word());
        emit(encode(op_load, 5'd1, 5'd0, 5'd0, 12'h400));
        emit(encode(op_add, 5'd2, 5'd1, 5'd1, 12'h0));
        store_rs(5'd2, 12'h600);
        emit(encode(op_load, 5'd3, 5'd0, 5'd0, 12'h408));
        store_rs(5'd3, 12'h608);
        emit(encode(op_load, 5'd4, 5'd0, 5'd0, 12'h410));
        emit(encode(op_addi, 5'd4, 5'd0, 5'd0, 12'h801));
        store_rs(5'd4, 12'h610);
        emit(encode(op_halt, 5'd0, 5'd0, 5'd0, 12'h0));
        run_test("load_use");

        // taken and not taken branches, stores in the shadow
        clear_image();
        put_word(32'h400, 64'd5);
        put_word(32'h408, -64'sd3);
        put_word(32'h410, pc_at(6));
        put_word(32'h418, pc_at(16));
        put_word(32'h420, 64'd8);
        put_word(32'h428, pc_at(26));
        emit(encode(op_load, 5'd1, 5'd0, 5'd0, 12'h400));
        emit(encode(op_load, 5'd2, 5'd0, 5'd0, 12'h408));
        emit(encode(op_load, 5'd20, 5'd0, 5'd0, 12'h410));
        emit(encode(op_brnz, 5'd20, 5'd1, 5'd0, 12'h0));
        store_rs(5'd1, 12'h600);
        store_rs(5'd1, 12'h608);
        store_rs(5'd1, 12'h610);
        emit(encode(op_brnz, 5'd20, 5'd0, 5'd0, 12'h0));
        store_rs(5'd2, 12'h618);
        emit(encode(op_brgt, 5'd20, 5'd2, 5'd1, 12'h0));
        store_rs(5'd1, 12'h620);
        emit(encode(op_load, 5'd21, 5'd0, 5'd0, 12'h418));
        emit(encode(op_brgt, 5'd21, 5'd1, 5'd2, 12'h0));
        store_rs(5'd1, 12'h628);
        store_rs(5'd1, 12'h630);
        store_rs(5'd1, 12'h638);
        emit(encode(op_brr_l, 5'd0, 5'd0, 5'd0, 12'd12));
        store_rs(5'd1, 12'h640);
        store_rs(5'd1, 12'h648);
        store_rs(5'd2, 12'h650);
        emit(encode(op_load, 5'd22, 5'd0, 5'd0, 12'h420));
        emit(encode(op_brr_rd, 5'd22, 5'd0, 5'd0, 12'h0));
        store_rs(5'd1, 12'h658);
        emit(encode(op_load, 5'd23, 5'd0, 5'd0, 12'h428));
        emit(encode(op_br, 5'd23, 5'd0, 5'd0, 12'h0));
        store_rs(5'd1, 12'h660);
        store_rs(5'd1, 12'h668);
        emit(encode(op_halt, 5'd0, 5'd0, 5'd0, 12'h0));
        run_test("branch");

        // nothing behind a halt may store
        clear_image();
        put_word(32'h400, rand_word());
        emit(encode(op_load, 5'd1, 5'd0, 5'd0, 12'h400));
        store_rs(5'd1, 12'h600);
        emit(encode(op_halt, 5'd0, 5'd0, 5'd0, 12'h0));
        store_rs(5'd1, 12'h608);
        store_rs(5'd1, 12'h610);
        emit(encode(op_addi, 5'd1, 5'd0, 5'd0, 12'h001));
        store_rs(5'd1, 12'h618);
        run_test("halt");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tinker_core.sv
`default_nettype none

module tinker_core (
    input  wire                     clk,
    input  wire                     reset,
    output tinker_pkg::addr_t       imem_addr,
    input  wire tinker_pkg::instr_t imem_data,
    output tinker_pkg::addr_t       dmem_addr,
    input  wire tinker_pkg::word_t  dmem_rdata,
    output tinker_pkg::word_t       dmem_wdata,
    output logic                    dmem_write,
    output logic                    hlt
);
    import tinker_pkg::*;

    // stage to stage buses
    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    redirect_t redirect;
    wb_t       wb;

    // back-pressure from decode to fetch
    logic stall;
    logic halt_fetch;

    fetch_unit u_fetch (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .stall      (stall),
        .halt_fetch (halt_fetch),
        .redirect   (redirect),
        .if_id      (if_id)
    );

    decode_stage u_decode (
        .clk        (clk),
        .reset      (reset),
        .if_id      (if_id),
        .redirect   (redirect),
        .wb         (wb),
        .stall      (stall),
        .halt_fetch (halt_fetch),
        .id_ex      (id_ex)
    );

    execute_stage u_execute (
        .clk      (clk),
        .reset    (reset),
        .id_ex    (id_ex),
        .wb       (wb),
        .redirect (redirect),
        .ex_mem   (ex_mem)
    );

    memory_writeback u_memwb (
        .clk        (clk),
        .reset      (reset),
        .ex_mem     (ex_mem),
        .dmem_addr  (dmem_addr),
        .dmem_rdata (dmem_rdata),
        .dmem_wdata (dmem_wdata),
        .dmem_write (dmem_write),
        .wb         (wb),
        .hlt        (hlt)
    );

endmodule

`default_nettype wire

//--- tinker_pkg.sv
`default_nettype none

package tinker_pkg;

    // widths with a meaning of their own
    typedef logic [63:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] imm_t;

    localparam addr_t reset_pc    = 32'h0000_2000;
    localparam addr_t instr_bytes = 32'd4;

    // kept opcodes, encodings as in the tinker isa
    // anything else decodes to a no-op
    typedef enum logic [4:0] {
        op_and    = 5'h00,
        op_or     = 5'h01,
        op_xor    = 5'h02,
        op_not    = 5'h03,
        op_shftr  = 5'h04,
        op_shftri = 5'h05,
        op_shftl  = 5'h06,
        op_shftli = 5'h07,
        op_br     = 5'h08,
        op_brr_rd = 5'h09,
        op_brr_l  = 5'h0a,
        op_brnz   = 5'h0b,
        op_brgt   = 5'h0e,
        op_halt   = 5'h0f,
        op_load   = 5'h10,
        op_mov    = 5'h11,
        op_movl   = 5'h12,
        op_store  = 5'h13,
        op_add    = 5'h18,
        op_addi   = 5'h19,
        op_sub    = 5'h1a,
        op_subi   = 5'h1b
    } opcode_t;

    typedef enum logic {
        fetch_run,
        fetch_halted
    } fetch_state_t;

    // fetch/decode register
    typedef struct packed {
        logic   valid;
        addr_t  pc;
        instr_t instr;
    } if_id_t;

    // decode/execute register
    typedef struct packed {
        logic     valid;
        opcode_t  op;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        imm_t     imm;
        addr_t    pc;
        // operand 2 from rt, else from L
        logic     uses_rt;
        word_t    rs_val;
        word_t    rt_val;
        word_t    rd_val;
    } id_ex_t;

    // execute/memory register
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    result;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        addr_t    addr;
        word_t    store_data;
        logic     is_halt;
    } ex_mem_t;

    typedef struct packed {
        logic  taken;
        addr_t target;
    } redirect_t;

    // writeback bus, also the forwarding source
    typedef struct packed {
        logic     write;
        reg_idx_t rd;
        word_t    value;
    } wb_t;

endpackage

`default_nettype wire

//--- tinker_properties.sv
`default_nettype none

module tinker_properties (
    input wire                    clk,
    input wire                    reset,
    input wire                    hlt,
    input wire                    dmem_write,
    input wire tinker_pkg::addr_t imem_addr
);

    // hlt is sticky until the next reset
    a_hlt_sticky: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
        else $error("hlt fell outside reset");

    // nothing may store once the core has halted
    a_no_store_after_hlt: assert property (@(posedge clk) disable iff (reset)
        !(hlt && dmem_write))
        else $error("dmem_write high while hlt is high");

    // fetch addresses are word aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        imem_addr[1:0] == 2'b00)
        else $error("imem_addr not 4-aligned");

endmodule

`default_nettype wire
